// File: include/mem_stage_macros.svh
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Datapath widths
`define MS_NB_DATA 32
`define MS_NB_ADDR 32
`define MS_NB_PC   32
`define MS_NB_REG  5

// Data memory depth in 32-bit words
`define MS_MEM_WORDS 256

// Register written by jump-and-link
`define MS_LINK_REG 31

`endif

// File: hw/mem_stage_pkg.sv
`include "mem_stage_macros.svh"

package mem_stage_pkg;

    typedef logic [`MS_NB_DATA-1:0] data_t;
    typedef logic [`MS_NB_ADDR-1:0] addr_t;
    typedef logic [`MS_NB_PC-1:0]   pc_t;
    typedef logic [`MS_NB_REG-1:0]  reg_idx_t;

    // Word index width of the data memory
    localparam int MEM_AW = $clog2(`MS_MEM_WORDS);

    localparam reg_idx_t LINK_REG = `MS_LINK_REG;

    // Load and store size, encoded from the one-hot enables at the top
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    // Contents of the MEM/WB register
    typedef struct packed {
        logic     reg_write;            // Register file write enable
        reg_idx_t wb_reg;               // Destination register
        data_t    wb_data;              // Value to write back
        logic     halt;                 // Halt travelling down the pipe
    } wb_payload_t;

    // Sticky halt state
    typedef struct packed {
        logic halted;                   // Set on first halt, cleared by reset
        pc_t  pc;                       // PC of the halting instruction
    } halt_status_t;

endpackage

// File: hw/mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if
    import mem_stage_pkg::*;
();

    logic         read;                 // Load request
    logic         write;                // Store request
    access_size_e size;                 // Access size
    addr_t        addr;                 // Byte address
    data_t        wdata;                // Store data, right aligned
    data_t        rdata;                // Load data, one cycle after the request

    modport requester (
        output read, write, size, addr, wdata,
        input  rdata
    );

    modport memory (
        input  read, write, size, addr, wdata,
        output rdata
    );

    // Writeback only needs the load data and whether a load was issued
    modport monitor (
        input  read, rdata
    );

endinterface

// File: hw/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter type T = logic
) (
    input  logic i_clock,
    input  logic i_arst_n,
    input  logic i_en,
    input  T     i_d,
    output T     o_q
);

    T q;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            q <= '0;
        end else if (i_en) begin
            q <= i_d;
        end
    end

    assign o_q = q;

endmodule

// File: hw/data_memory.sv
`timescale 1ns/10ps

`include "mem_stage_macros.svh"

module data_memory
    import mem_stage_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_arst_n,
    mem_req_if.memory  mem,

    input  logic       i_psel,
    input  logic       i_penable,
    input  logic       i_pwrite,
    input  addr_t      i_paddr,
    input  data_t      i_pwdata,
    output data_t      o_prdata,
    output logic       o_pready,
    output logic       o_pslverr
);

    data_t             mem_q [`MS_MEM_WORDS];
    logic [MEM_AW-1:0] pipe_idx;
    logic [MEM_AW-1:0] apb_idx;
    logic [3:0]        byte_en;
    data_t             store_data;
    data_t             word_rd;
    data_t             load_data;
    data_t             rdata_q;
    logic [7:0]        load_byte;
    logic [15:0]       load_half;
    logic              pipe_busy;
    logic              apb_access;
    logic              apb_fire;
    logic              range_err;

    assign pipe_idx = mem.addr[MEM_AW+1:2];     // Low two bits pick the lane
    assign apb_idx  = i_paddr[MEM_AW+1:2];

    // Store lanes, little-endian
    always_comb begin
        case (mem.size)
            SIZE_BYTE: begin
                byte_en    = 4'b0001 << mem.addr[1:0];
                store_data = {4{mem.wdata[7:0]}};
            end
            SIZE_HALF: begin
                byte_en    = mem.addr[1] ? 4'b1100 : 4'b0011;  // Bit 0 ignored
                store_data = {2{mem.wdata[15:0]}};
            end
            default: begin
                byte_en    = 4'b1111;
                store_data = mem.wdata;
            end
        endcase
    end

    // Load extraction with sign extension
    assign word_rd   = mem_q[pipe_idx];
    assign load_byte = word_rd[8*mem.addr[1:0] +: 8];
    assign load_half = mem.addr[1] ? word_rd[31:16] : word_rd[15:0];

    always_comb begin
        case (mem.size)
            SIZE_BYTE: load_data = {{24{load_byte[7]}}, load_byte};
            SIZE_HALF: load_data = {{16{load_half[15]}}, load_half};
            default:   load_data = word_rd;
        endcase
    end

    // APB only gets the array when the pipeline leaves it alone
    assign pipe_busy  = mem.read | mem.write;
    assign apb_access = i_psel & i_penable;
    assign o_pready   = ~(apb_access & pipe_busy);
    assign apb_fire   = apb_access & ~pipe_busy;
    assign range_err  = i_paddr >= addr_t'(`MS_MEM_WORDS * 4);
    assign o_pslverr  = apb_fire & range_err;
    assign o_prdata   = range_err ? '0 : mem_q[apb_idx];

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int w = 0; w < `MS_MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (mem.write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem_q[pipe_idx][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end else if (apb_fire && i_pwrite && !range_err) begin
            mem_q[apb_idx] <= i_pwdata;                 // Out-of-range writes dropped
        end
    end

    always_ff @(posedge i_clock) begin
        if (mem.read) begin
            rdata_q <= load_data;
        end
    end

    assign mem.rdata = rdata_q;

endmodule

// File: hw/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve
    import mem_stage_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_arst_n,
    input  logic         i_branch,
    input  logic         i_zero,
    input  pc_t          i_branch_addr,
    input  logic         i_hlt,
    input  pc_t          i_pc,
    output logic         o_branch_taken,
    output pc_t          o_branch_addr,
    output halt_status_t o_halt_status
);

    halt_status_t halt_d;
    halt_status_t halt_q;
    logic         halt_capture;

    // IF redirect, no register
    assign o_branch_taken = i_branch & i_zero;
    assign o_branch_addr  = i_branch_addr;

    // Only the first halt is recorded
    assign halt_capture  = i_hlt & ~halt_q.halted;
    assign halt_d.halted = 1'b1;
    assign halt_d.pc     = i_pc;

    stage_reg #(
        .T (halt_status_t)
    ) halt_reg_i (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_en     (halt_capture),
        .i_d      (halt_d),
        .o_q      (halt_q)
    );

    assign o_halt_status = halt_q;

endmodule

// File: hw/writeback_select.sv
`timescale 1ns/10ps

module writeback_select
    import mem_stage_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_arst_n,
    mem_req_if.monitor  mem,
    input  logic        i_reg_write,
    input  logic        i_mem_to_reg,
    input  logic        i_r31_ctrl,
    input  reg_idx_t    i_sel_reg,
    input  data_t       i_alu_result,
    input  pc_t         i_pc,
    input  logic        i_hlt,
    output wb_payload_t o_wb
);

    wb_payload_t wb_d;
    wb_payload_t wb_q;
    logic        load_q;

    // Link writes the incoming PC into r31
    always_comb begin
        wb_d.reg_write = i_reg_write;
        wb_d.halt      = i_hlt;
        if (i_r31_ctrl) begin
            wb_d.wb_reg  = LINK_REG;
            wb_d.wb_data = i_pc;
        end else begin
            wb_d.wb_reg  = i_sel_reg;
            wb_d.wb_data = i_alu_result;
        end
    end

    stage_reg #(
        .T (wb_payload_t)
    ) wb_reg_i (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_en     (1'b1),                   // One item per cycle, never stalls
        .i_d      (wb_d),
        .o_q      (wb_q)
    );

    // Load data arrives with the edge, so its select is registered
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= i_mem_to_reg & mem.read;
        end
    end

    // Memory data wins over link and ALU result
    always_comb begin
        o_wb = wb_q;
        if (load_q) begin
            o_wb.wb_data = mem.rdata;
        end
    end

endmodule

// File: hw/mem_stage_top.sv
`timescale 1ns/10ps

module mem_stage_top
    import mem_stage_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_arst_n,

    input  logic     i_mem_read,
    input  logic     i_mem_write,
    input  logic     i_word_en,
    input  logic     i_halfword_en,
    input  logic     i_byte_en,

    input  data_t    i_alu_result,      // Memory address or ALU value
    input  data_t    i_write_data,      // Store data

    input  logic     i_branch,
    input  logic     i_zero,
    input  pc_t      i_branch_addr,

    input  logic     i_reg_write,
    input  logic     i_mem_to_reg,
    input  logic     i_r31_ctrl,
    input  reg_idx_t i_sel_reg,         // rd or rt
    input  pc_t      i_pc,
    input  logic     i_hlt,

    input  logic     i_psel,
    input  logic     i_penable,
    input  logic     i_pwrite,
    input  addr_t    i_paddr,
    input  data_t    i_pwdata,
    output data_t    o_prdata,
    output logic     o_pready,
    output logic     o_pslverr,

    output logic     o_branch_taken,    // IF mux select
    output pc_t      o_branch_addr,
    output logic     o_wb_reg_write,
    output reg_idx_t o_wb_reg,
    output data_t    o_wb_data,
    output logic     o_wb_halt,
    output logic     o_halted,
    output pc_t      o_halt_pc
);

    mem_req_if    mem_if ();
    access_size_e size;
    halt_status_t halt_status;
    wb_payload_t  wb;

    // One-hot enables, word when none is set
    always_comb begin
        case ({i_word_en, i_halfword_en, i_byte_en})
            3'b001:  size = SIZE_BYTE;
            3'b010:  size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
    end

    assign mem_if.read  = i_mem_read;
    assign mem_if.write = i_mem_write;
    assign mem_if.size  = size;
    assign mem_if.addr  = i_alu_result;
    assign mem_if.wdata = i_write_data;

    data_memory data_memory_i (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .mem       (mem_if.memory),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    branch_resolve branch_resolve_i (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_branch       (i_branch),
        .i_zero         (i_zero),
        .i_branch_addr  (i_branch_addr),
        .i_hlt          (i_hlt),
        .i_pc           (i_pc),
        .o_branch_taken (o_branch_taken),
        .o_branch_addr  (o_branch_addr),
        .o_halt_status  (halt_status)
    );

    writeback_select writeback_select_i (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .mem          (mem_if.monitor),
        .i_reg_write  (i_reg_write),
        .i_mem_to_reg (i_mem_to_reg),
        .i_r31_ctrl   (i_r31_ctrl),
        .i_sel_reg    (i_sel_reg),
        .i_alu_result (i_alu_result),
        .i_pc         (i_pc),
        .i_hlt        (i_hlt),
        .o_wb         (wb)
    );

    assign o_wb_reg_write = wb.reg_write;
    assign o_wb_reg       = wb.wb_reg;
    assign o_wb_data      = wb.wb_data;
    assign o_wb_halt      = wb.halt;
    assign o_halted       = halt_status.halted;
    assign o_halt_pc      = halt_status.pc;

endmodule

// File: dv/mem_stage_asserts.sv
`timescale 1ns/10ps

module mem_stage_asserts (
    input logic i_clock,
    input logic i_arst_n,
    input logic i_branch,
    input logic i_zero,
    input logic i_mem_read,
    input logic i_mem_write,
    input logic i_psel,
    input logic i_penable,
    input logic o_branch_taken,
    input logic o_pready,
    input logic o_halted
);

    branch_rule: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_branch_taken == (i_branch & i_zero))
        else $error("o_branch_taken differs from i_branch and i_zero");

    // Pipeline owns the array, APB must wait
    wait_rule: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_psel && i_penable && (i_mem_read || i_mem_write)) |-> !o_pready)
        else $error("o_pready high while a pipeline access is in progress");

    sticky_halt_rule: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !$fell(o_halted))
        else $error("o_halted fell outside reset");

endmodule

// File: dv/mem_stage_tb.sv
`timescale 1ns/10ps

`include "mem_stage_macros.svh"

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int HALF_PERIOD = 50;
    localparam int QUARTER     = 25;            // Mid low phase, clear of both edges

    typedef struct packed {
        logic [7:0]       op;
        logic [5:0][31:0] f;                    // Fields in file order, f[0] first
    } test_t;

    logic     i_clock, i_arst_n;
    logic     i_mem_read, i_mem_write, i_word_en, i_halfword_en, i_byte_en;
    logic     i_branch, i_zero, i_reg_write, i_mem_to_reg, i_r31_ctrl, i_hlt;
    logic     i_psel, i_penable, i_pwrite;
    data_t    i_alu_result, i_write_data, i_pwdata;
    pc_t      i_branch_addr, i_pc;
    reg_idx_t i_sel_reg;
    addr_t    i_paddr;
    data_t    o_prdata, o_wb_data;
    logic     o_pready, o_pslverr, o_branch_taken, o_wb_reg_write, o_wb_halt, o_halted;
    pc_t      o_branch_addr, o_halt_pc;
    reg_idx_t o_wb_reg;

    test_t tests[$];
    int    checks = 0;
    int    errors = 0;
    int    test_errs = 0;
    int    cycles = 0;
    int    limit = 0;
    int    seed_val;

    mem_stage_top dut_i (.*);

    bind mem_stage_top mem_stage_asserts asserts_i (.*);

    initial begin
        i_clock = 1'b0;
        forever #(HALF_PERIOD) i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_halt(input halt_status_t got, input halt_status_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED halt status: got %h, expected %h", got, exp);
            test_errs++;
        end
    endtask

    task automatic drive_idle();
        {i_mem_read, i_mem_write, i_word_en, i_halfword_en, i_byte_en} = '0;
        {i_branch, i_zero, i_reg_write, i_mem_to_reg, i_r31_ctrl, i_hlt} = '0;
        {i_alu_result, i_write_data, i_branch_addr, i_pc, i_sel_reg} = '0;
    endtask

    task automatic drive_mem(input logic rd, input logic wr, input logic [1:0] sz,
                             input addr_t addr, input data_t wdata);
        i_mem_read    = rd;
        i_mem_write   = wr;
        i_byte_en     = (sz == 2'd0);           // Size 0 byte, 1 half, 2 word
        i_halfword_en = (sz == 2'd1);
        i_word_en     = (sz == 2'd2);
        i_alu_result  = addr;
        i_write_data  = wdata;
    endtask

    // Setup phase, then access phase from the next falling edge
    task automatic apb_setup(input logic wr, input addr_t addr, input data_t wdata);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge i_clock);
        i_penable = 1'b1;
    endtask

    task automatic apb_complete(output data_t rd, output logic err);
        #(QUARTER);
        while (!o_pready) begin
            @(negedge i_clock);
            #(QUARTER);
        end
        rd  = o_prdata;
        err = o_pslverr;
        @(negedge i_clock);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata,
                            output data_t rd, output logic err);
        apb_setup(wr, addr, wdata);
        apb_complete(rd, err);
    endtask

    task automatic read_stimulus();
        int               fd;
        logic [8*160-1:0] line;
        logic [7:0]       op;
        data_t            f1, f2, f3, f4, f5, f6;
        test_t            t;
        fd = $fopen("dv/mem_stage_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%s %h %h %h %h %h %h", op, f1, f2, f3, f4, f5, f6) == 7) begin
                t.op = op;
                t.f  = {f6, f5, f4, f3, f2, f1};
                tests.push_back(t);
            end
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            $display("The stimulus file holds no tests");
            errors++;
        end
    endtask

    task automatic run_test(input test_t t);
        data_t        rd;
        data_t        rnd;
        logic         err;
        halt_status_t exp_h;
        halt_status_t got_h;
        case (t.op)
            "W", "L": begin
                drive_mem(t.op == "L", t.op == "W", t.f[0][1:0], t.f[1], t.f[2]);
                i_reg_write  = (t.op == "L");
                i_mem_to_reg = (t.op == "L");
                i_sel_reg    = t.f[2][4:0];
                @(negedge i_clock);
                drive_idle();
                if (t.op == "L") begin
                    check_data("o_wb_data", o_wb_data, t.f[3]);
                    check_reg("o_wb_reg", o_wb_reg, t.f[2][4:0]);
                    check_bit("o_wb_reg_write", o_wb_reg_write, 1'b1);
                end
            end
            "A": begin
                i_alu_result = t.f[0];
                i_sel_reg    = t.f[1][4:0];
                i_r31_ctrl   = t.f[2][0];
                i_pc         = t.f[3];
                i_reg_write  = 1'b1;
                i_mem_read   = 1'b1;            // Load in flight, mem-to-reg still clear
                @(negedge i_clock);
                drive_idle();
                check_data("o_wb_data", o_wb_data, t.f[4]);
                check_reg("o_wb_reg", o_wb_reg,
                          t.f[2][0] ? reg_idx_t'(`MS_LINK_REG) : reg_idx_t'(t.f[1][4:0]));
            end
            "B": begin
                i_branch      = t.f[0][0];
                i_zero        = t.f[1][0];
                i_branch_addr = t.f[2];
                #(QUARTER);
                check_bit("o_branch_taken", o_branch_taken, t.f[3][0]);
                check_data("o_branch_addr", o_branch_addr, t.f[2]);
                @(negedge i_clock);
                drive_idle();
            end
            "P": begin
                apb_xfer(t.f[0][0], t.f[1], t.f[2], rd, err);
                check_bit("o_pslverr", err, t.f[4][0]);
                if (!t.f[0][0] && !t.f[4][0])
                    check_data("o_prdata", rd, t.f[3]);
            end
            "H": begin
                i_hlt        = 1'b1;
                i_pc         = t.f[0];
                exp_h.halted = 1'b1;
                exp_h.pc     = t.f[1];
                for (int c = 1; c >= 0; c--) begin
                    @(negedge i_clock);
                    drive_idle();
                    got_h = {o_halted, o_halt_pc};
                    check_bit("o_wb_halt", o_wb_halt, c[0]);     // One cycle pulse
                    check_halt(got_h, exp_h);
                end
            end
            "C": begin
                rnd = $urandom();
                apb_setup(1'b1, t.f[2], rnd);
                drive_mem(1'b0, 1'b1, 2'd2, t.f[0], t.f[1]);
                #(QUARTER);
                check_bit("o_pready", o_pready, 1'b0);
                @(negedge i_clock);
                drive_idle();
                apb_complete(rd, err);
                check_bit("o_pslverr", err, 1'b0);
                apb_xfer(1'b0, t.f[2], '0, rd, err);
                check_data("o_prdata", rd, rnd);
            end
            default: begin
                $display("Unknown operation %c in the stimulus file", t.op);
                test_errs++;
            end
        endcase
    endtask

    task automatic finish_test(input int n, input logic [7:0] op);
        errors += test_errs;
        if (test_errs == 0)
            $display("test %0d (%c) ok", n, op);
        else
            $display("test %0d (%c) had %0d mismatches", n, op, test_errs);
    endtask

    initial begin
        seed_val = $urandom(32'he9d47c9e);
        i_arst_n = 1'b0;
        {i_psel, i_penable, i_pwrite, i_paddr, i_pwdata} = '0;
        drive_idle();
        read_stimulus();
        limit = tests.size() * 8 + 50;
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        i_arst_n = 1'b1;
        check_bit("o_wb_reg_write", o_wb_reg_write, 1'b0);
        check_bit("o_wb_halt", o_wb_halt, 1'b0);
        check_bit("o_halted", o_halted, 1'b0);
        check_bit("o_pready", o_pready, 1'b1);
        finish_test(0, "R");
        foreach (tests[i]) begin
            test_errs = 0;
            run_test(tests[i]);
            finish_test(i + 1, tests[i].op);
        end
        $display("%0d tests, %0d checks, %0d failing", tests.size() + 1, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: dv/mem_stage_stimulus.txt
# Columns: op f1 f2 f3 f4 f5 f6, hex, unused fields zero. Size 0 byte, 1 half, 2 word
# W size addr wdata | L size addr reg exp_data | A alu reg r31 pc exp_data
# B branch zero target exp_taken | P write addr wdata exp_rdata exp_err
# H pc exp_halt_pc | C store_addr store_data apb_addr
L 2 00000080 03 00000000 0 0
W 2 00000010 deadbeef 0 0 0
L 2 00000010 05 deadbeef 0 0
L 2 00000013 06 deadbeef 0 0
L 0 00000010 07 ffffffef 0 0
L 0 00000011 07 ffffffbe 0 0
L 0 00000012 07 ffffffad 0 0
L 0 00000013 07 ffffffde 0 0
L 1 00000010 08 ffffbeef 0 0
L 1 00000011 08 ffffbeef 0 0
L 1 00000012 08 ffffdead 0 0
W 0 00000011 00000042 0 0 0
L 2 00000010 09 dead42ef 0 0
L 0 00000011 09 00000042 0 0
W 1 00000013 00001234 0 0 0
L 2 00000010 0a 123442ef 0 0
L 1 00000012 0a 00001234 0 0
W 1 00000010 0000807f 0 0 0
L 1 00000010 0b ffff807f 0 0
L 0 00000011 0b ffffff80 0 0
L 2 00000010 0b 1234807f 0 0
W 0 00000023 00000080 0 0 0
L 2 00000020 0c 80000000 0 0
L 0 00000023 0c ffffff80 0 0
A 00001111 0c 0 00000400 00001111 0
A 00002222 0d 1 00000404 00000404 0
A 0000ffff 1e 0 00000408 0000ffff 0
B 1 1 00000abc 1 0 0
B 1 0 00000abc 0 0 0
B 0 1 00000123 0 0 0
B 0 0 00000000 0 0 0
B 1 1 fffffffc 1 0 0
P 1 00000040 cafef00d 0 0 0
P 0 00000040 0 cafef00d 0 0
L 2 00000040 0e cafef00d 0 0
W 2 00000044 13572468 0 0 0
P 0 00000044 0 13572468 0 0
P 1 00000400 11111111 0 1 0
P 0 00000400 0 0 1 0
P 0 00000000 0 00000000 0 0
P 1 000003fc 55aa55aa 0 0 0
L 2 000003fc 0f 55aa55aa 0 0
C 00000050 a5a5a5a5 00000054 0 0 0
L 2 00000050 10 a5a5a5a5 0 0
H 00000200 00000200 0 0 0 0
H 00000300 00000200 0 0 0 0
L 2 00000010 11 1234807f 0 0

// File: mem_stage_top.f
+incdir+include
hw/mem_stage_pkg.sv
hw/mem_req_if.sv
hw/stage_reg.sv
hw/data_memory.sv
hw/branch_resolve.sv
hw/writeback_select.sv
hw/mem_stage_top.sv
dv/mem_stage_asserts.sv
dv/mem_stage_tb.sv
